//--- rtl/dCache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// byte address width
`define DC_ADDR_WIDTH 32

// geometry
`define DC_SETS 8
`define DC_WORDS_PER_LINE 4

// tag is address bits 31..7
`define DC_TAG_WIDTH 25

// backing memory, 1 KB of words
`define DC_MEM_WORDS 256

// default memory latency in cycles
`define DC_MEM_LATENCY 2

`endif

//--- rtl/dCachePkg.sv
`default_nettype none

package dCachePkg;

    // one data word, seen whole or as byte lanes
    typedef union packed {
        logic [31:0]       word;
        logic [3:0][7:0]   bytes;   // bytes[0] is the low lane
    } dataWord_u;

    // decoded access kind
    typedef enum logic [1:0] {
        LW  = 2'b00,
        LBU = 2'b01,
        SW  = 2'b10,
        SB  = 2'b11
    } accessKind_e;

endpackage

`default_nettype wire

//--- rtl/accessDecode.sv
`timescale 1ns/1ps
`default_nettype none
`include "dCache_consts.svh"

module accessDecode
    import dCachePkg::*;
(
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               memRead,
    input  logic                               memWrite,
    input  logic                               ldByte,
    input  logic                               stByte,
    input  logic [`DC_ADDR_WIDTH-1:0]          address,
    input  logic [31:0]                        writeData,
    input  logic                               ready,
    output logic                               reqValid,
    output accessKind_e                        kind,
    output logic [`DC_TAG_WIDTH-1:0]           tag,
    output logic [$clog2(`DC_SETS)-1:0]        setIdx,
    output logic [$clog2(`DC_WORDS_PER_LINE)-1:0] wordOff,
    output logic [1:0]                         byteOff,
    output dataWord_u                          storeData
);
    localparam int WordLsb = 2;
    localparam int SetLsb = WordLsb + $clog2(`DC_WORDS_PER_LINE);

    logic        accept;
    accessKind_e kindNext;
    dataWord_u   dataNext;

    assign accept = ready && (memRead || memWrite);   // strobes while busy are dropped

    always_comb begin
        if (memWrite) begin
            kindNext = stByte ? SB : SW;
        end else begin
            kindNext = ldByte ? LBU : LW;
        end
        dataNext.word = writeData;
        // SB: low byte copied to every lane, lane picked later by byteOff
        if (memWrite && stByte) begin
            dataNext.bytes = {4{writeData[7:0]}};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            reqValid <= 1'b0;
        end else begin
            reqValid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            kind      <= kindNext;
            tag       <= address[`DC_ADDR_WIDTH-1 -: `DC_TAG_WIDTH];
            setIdx    <= address[SetLsb +: $clog2(`DC_SETS)];
            wordOff   <= address[WordLsb +: $clog2(`DC_WORDS_PER_LINE)];
            byteOff   <= address[1:0];
            storeData <= dataNext;
        end
    end

endmodule

`default_nettype wire

//--- rtl/cacheWays.sv
`timescale 1ns/1ps
`default_nettype none
`include "dCache_consts.svh"

module cacheWays
    import dCachePkg::*;
(
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [`DC_TAG_WIDTH-1:0]              tag,
    input  logic [$clog2(`DC_SETS)-1:0]           setIdx,
    input  logic [$clog2(`DC_WORDS_PER_LINE)-1:0] wordOff,
    input  logic [1:0]                            byteOff,
    input  dataWord_u                             storeData,
    input  accessKind_e                           kind,
    input  logic                                  refillWe,
    input  logic [$clog2(`DC_WORDS_PER_LINE)-1:0] refillWord,
    input  logic [31:0]                           refillData,
    input  logic                                  storeWe,
    input  logic                                  touch,
    output logic                                  wayHit,
    output logic                                  hitWay,
    output logic [`DC_WORDS_PER_LINE*32-1:0]      lineData
);
    localparam int WordBits = $clog2(`DC_WORDS_PER_LINE);
    localparam logic [WordBits-1:0] LastWord = WordBits'(`DC_WORDS_PER_LINE - 1);

    // storage per way, indexed [way][set]
    logic [`DC_WORDS_PER_LINE-1:0][31:0] lineMem [2][`DC_SETS];
    logic [`DC_TAG_WIDTH-1:0]            tagMem [2][`DC_SETS];
    logic [`DC_SETS-1:0]                 validBits [2];
    logic [`DC_SETS-1:0]                 lruBits;   // holds the victim way of each set

    logic      hit0;
    logic      hit1;
    logic      victim;
    dataWord_u mergedWord;

    assign hit0 = validBits[0][setIdx] && (tagMem[0][setIdx] == tag);
    assign hit1 = validBits[1][setIdx] && (tagMem[1][setIdx] == tag);

    assign wayHit   = hit0 || hit1;
    assign hitWay   = hit1;
    assign victim   = lruBits[setIdx];
    assign lineData = lineMem[hitWay][setIdx];   // way0 line on a miss, unused then

    // store merge into the hit word
    always_comb begin
        mergedWord.word = lineMem[hitWay][setIdx][wordOff];
        if (kind == SB) begin
            mergedWord.bytes[byteOff] = storeData.bytes[byteOff];
        end else begin
            mergedWord.word = storeData.word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            validBits[0] <= '0;
            validBits[1] <= '0;
            lruBits      <= '0;
        end else begin
            // victim goes invalid on the first refill word, valid after the last
            if (refillWe && refillWord == '0) begin
                validBits[victim][setIdx] <= 1'b0;
            end
            if (refillWe && refillWord == LastWord) begin
                validBits[victim][setIdx] <= 1'b1;
            end
            if (touch && wayHit) begin
                lruBits[setIdx] <= ~hitWay;   // other way becomes LRU
            end
        end
    end

    always_ff @(posedge clk) begin
        if (refillWe) begin
            lineMem[victim][setIdx][refillWord] <= refillData;
            tagMem[victim][setIdx]              <= tag;
        end
        if (storeWe && wayHit) begin
            lineMem[hitWay][setIdx][wordOff] <= mergedWord.word;
        end
    end

endmodule

`default_nettype wire

//--- rtl/cacheController.sv
`timescale 1ns/1ps
`default_nettype none
`include "dCache_consts.svh"

module cacheController
    import dCachePkg::*;
(
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  reqValid,
    input  accessKind_e                           kind,
    input  logic [`DC_TAG_WIDTH-1:0]              tag,
    input  logic [$clog2(`DC_SETS)-1:0]           setIdx,
    input  logic [$clog2(`DC_WORDS_PER_LINE)-1:0] wordOff,
    input  logic [1:0]                            byteOff,
    input  dataWord_u                             storeData,
    input  logic                                  wayHit,
    output logic                                  ready,
    output logic                                  done,
    output logic                                  hit,
    output logic                                  refillWe,
    output logic [$clog2(`DC_WORDS_PER_LINE)-1:0] refillWord,
    output logic [31:0]                           refillData,
    output logic                                  storeWe,
    output logic                                  touch,
    output logic                                  memReq,
    output logic                                  memWe,
    output logic [`DC_ADDR_WIDTH-1:0]             memAddr,
    output logic [3:0]                            memByteEn,
    output logic [31:0]                           memWData,
    input  logic                                  memAck,
    input  logic [31:0]                           memRData
);
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REFILL_REQ,
        REFILL_WAIT,
        STORE_WAIT,
        RESPOND
    } ctrlState_e;

    ctrlState_e state;
    ctrlState_e nextState;
    logic [$clog2(`DC_WORDS_PER_LINE)-1:0] refillCnt;
    logic hitReg;
    logic isStore;

    assign isStore = (kind == SW) || (kind == SB);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            refillCnt <= '0;
            hitReg    <= 1'b0;
        end else begin
            state <= nextState;
            if (state == LOOKUP) begin
                hitReg    <= wayHit;
                refillCnt <= '0;
            end else if (state == REFILL_WAIT && memAck) begin
                refillCnt <= refillCnt + 1'b1;
            end
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            IDLE:        if (reqValid) nextState = LOOKUP;
            LOOKUP: begin
                if (isStore) begin
                    nextState = STORE_WAIT;   // write-through, hit or miss
                end else if (wayHit) begin
                    nextState = RESPOND;
                end else begin
                    nextState = REFILL_REQ;
                end
            end
            REFILL_REQ:  nextState = REFILL_WAIT;
            REFILL_WAIT: if (memAck) nextState = (refillCnt == '1) ? RESPOND : REFILL_REQ;
            STORE_WAIT:  if (memAck) nextState = RESPOND;
            RESPOND:     nextState = IDLE;
            default:     nextState = IDLE;
        endcase
    end

    // busy from the cycle after acceptance through the done cycle
    assign ready = (state == IDLE) && !reqValid;
    assign done  = (state == RESPOND);
    assign hit   = done && hitReg;
    assign touch = done;   // ways ignore it unless the line hits

    assign refillWe   = (state == REFILL_WAIT) && memAck;
    assign refillWord = refillCnt;
    assign refillData = memRData;
    assign storeWe    = (state == LOOKUP) && isStore && wayHit;

    assign memWe     = (state == LOOKUP) && isStore;
    assign memReq    = memWe || (state == REFILL_REQ);
    assign memAddr   = {tag, setIdx, (memWe ? wordOff : refillCnt), 2'b00};
    assign memByteEn = (kind == SB) ? (4'b0001 << byteOff) : 4'b1111;
    assign memWData  = storeData.word;

endmodule

`default_nettype wire

//--- rtl/loadFormatter.sv
`timescale 1ns/1ps
`default_nettype none
`include "dCache_consts.svh"

module loadFormatter
    import dCachePkg::*;
(
    input  logic [`DC_WORDS_PER_LINE*32-1:0]      lineData,
    input  logic [$clog2(`DC_WORDS_PER_LINE)-1:0] wordOff,
    input  logic [1:0]                            byteOff,
    input  accessKind_e                           kind,
    output logic [31:0]                           readData
);
    dataWord_u selWord;

    assign selWord.word = lineData[32*wordOff +: 32];

    always_comb begin
        if (kind == LBU) begin
            readData = {24'b0, selWord.bytes[byteOff]};   // zero extended
        end else begin
            readData = selWord.word;
        end
    end

endmodule

`default_nettype wire

//--- rtl/backingMemory.sv
`timescale 1ns/1ps
`default_nettype none
`include "dCache_consts.svh"

module backingMemory #(
    parameter int MEM_LATENCY = `DC_MEM_LATENCY
) (
    input  logic                      clk,
    input  logic                      memReq,
    input  logic                      memWe,
    input  logic [`DC_ADDR_WIDTH-1:0] memAddr,
    input  logic [3:0]                memByteEn,
    input  logic [31:0]               memWData,
    output logic                      memAck,
    output logic [31:0]               memRData
);
    localparam int IdxBits = $clog2(`DC_MEM_WORDS);
    localparam int CntBits = $clog2(MEM_LATENCY + 1);

    logic [31:0]        memArray [`DC_MEM_WORDS];
    logic [IdxBits-1:0] wordIdx;
    logic [CntBits-1:0] delayCnt = '0;

    assign wordIdx = memAddr[2 +: IdxBits];

    // access happens at the request edge, only the ack is delayed
    always_ff @(posedge clk) begin
        if (memReq && memWe) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (memByteEn[lane]) begin
                    memArray[wordIdx][8*lane +: 8] <= memWData[8*lane +: 8];
                end
            end
        end
        if (memReq && !memWe) begin
            memRData <= memArray[wordIdx];
        end
    end

    always_ff @(posedge clk) begin
        if (memReq) begin
            delayCnt <= CntBits'(MEM_LATENCY);
        end else if (delayCnt != '0) begin
            delayCnt <= delayCnt - 1'b1;
        end
    end

    assign memAck = (delayCnt == CntBits'(1));

endmodule

`default_nettype wire

//--- rtl/dataCacheTop.sv
`timescale 1ns/1ps
`default_nettype none
`include "dCache_consts.svh"

module dataCacheTop
    import dCachePkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      memRead,
    input  logic                      memWrite,
    input  logic                      ldByte,
    input  logic                      stByte,
    input  logic [`DC_ADDR_WIDTH-1:0] address,
    input  logic [31:0]               writeData,
    output logic [31:0]               readData,
    output logic                      hit,
    output logic                      done,
    output logic                      ready
);
    // decoded request
    logic                                  reqValid;
    accessKind_e                           kind;
    logic [`DC_TAG_WIDTH-1:0]              tag;
    logic [$clog2(`DC_SETS)-1:0]           setIdx;
    logic [$clog2(`DC_WORDS_PER_LINE)-1:0] wordOff;
    logic [1:0]                            byteOff;
    dataWord_u                             storeData;

    // controller to ways
    logic                                  refillWe;
    logic [$clog2(`DC_WORDS_PER_LINE)-1:0] refillWord;
    logic [31:0]                           refillData;
    logic                                  storeWe;
    logic                                  touch;
    logic                                  wayHit;
    logic                                  hitWay;
    logic [`DC_WORDS_PER_LINE*32-1:0]      lineData;

    // memory side
    logic                      memReq;
    logic                      memWe;
    logic [`DC_ADDR_WIDTH-1:0] memAddr;
    logic [3:0]                memByteEn;
    logic [31:0]               memWData;
    logic                      memAck;
    logic [31:0]               memRData;

    accessDecode uDecode (
        .clk, .rst, .memRead, .memWrite, .ldByte, .stByte, .address, .writeData, .ready,
        .reqValid, .kind, .tag, .setIdx, .wordOff, .byteOff, .storeData
    );

    cacheWays uWays (
        .clk, .rst, .tag, .setIdx, .wordOff, .byteOff, .storeData, .kind,
        .refillWe, .refillWord, .refillData, .storeWe, .touch,
        .wayHit, .hitWay, .lineData
    );

    cacheController uCtrl (
        .clk, .rst, .reqValid, .kind, .tag, .setIdx, .wordOff, .byteOff, .storeData, .wayHit,
        .ready, .done, .hit, .refillWe, .refillWord, .refillData, .storeWe, .touch,
        .memReq, .memWe, .memAddr, .memByteEn, .memWData, .memAck, .memRData
    );

    loadFormatter uFormat (
        .lineData, .wordOff, .byteOff, .kind, .readData
    );

    backingMemory #(.MEM_LATENCY(`DC_MEM_LATENCY)) uMem (
        .clk, .memReq, .memWe, .memAddr, .memByteEn, .memWData, .memAck, .memRData
    );

endmodule

`default_nettype wire

//--- tb/dataCacheTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "dCache_consts.svh"

module dataCacheTb;
    localparam int WaitLimit = 200;   // cycles allowed for any one wait

    logic        clk = 1'b0;
    logic        rst;
    logic        memRead, memWrite, ldByte, stByte;
    logic [31:0] address;
    logic [31:0] writeData;
    logic [31:0] readData;
    logic        hit, done, ready;

    // reference byte memory plus a model of tags, valid and LRU bits
    logic [7:0]  refMem [`DC_MEM_WORDS*4];
    logic        modelValid [2][`DC_SETS];
    logic [24:0] modelTag [2][`DC_SETS];
    logic        modelLru [`DC_SETS];   // victim way per set
    logic        lastHit;
    integer      seed;

    dataCacheTop UUT (
        .clk, .rst, .memRead, .memWrite, .ldByte, .stByte, .address, .writeData,
        .readData, .hit, .done, .ready
    );

    always #2 clk = ~clk;

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] refWord(input logic [9:0] byteAddr);
        logic [9:0] base;
        base = {byteAddr[9:2], 2'b00};
        return {refMem[base + 10'd3], refMem[base + 10'd2], refMem[base + 10'd1], refMem[base]};
    endfunction

    // predicts the hit and then updates allocation and LRU
    task automatic modelAccess(input logic [31:0] addr, input logic isLoad, output logic expHit);
        logic [2:0] setIdx;
        logic       way;
        setIdx = addr[6:4];
        expHit = 1'b0;
        way = modelLru[setIdx];
        if (modelValid[0][setIdx] && modelTag[0][setIdx] == addr[31:7]) begin
            expHit = 1'b1;
            way = 1'b0;
        end else if (modelValid[1][setIdx] && modelTag[1][setIdx] == addr[31:7]) begin
            expHit = 1'b1;
            way = 1'b1;
        end
        if (expHit || isLoad) begin   // a store miss allocates nothing
            modelValid[way][setIdx] = 1'b1;
            modelTag[way][setIdx] = addr[31:7];
            modelLru[setIdx] = ~way;
        end
    endtask

    // starts on a falling edge and returns one cycle after acceptance
    task automatic issue(input logic [31:0] addr, input logic isWrite, input logic isByte,
                         input logic [31:0] data);
        int waitCycles;
        waitCycles = 0;
        while (!ready) begin
            @(negedge clk);
            waitCycles++;
            if (waitCycles > WaitLimit) failRun("timeout: ready never went high");
        end
        address = addr;
        writeData = data;
        memRead = !isWrite;
        memWrite = isWrite;
        ldByte = isByte;
        stByte = isByte;
        @(negedge clk);
        memRead = 1'b0;
        memWrite = 1'b0;
    endtask

    task automatic waitDone();
        int waitCycles;
        waitCycles = 0;
        while (!done) begin
            @(negedge clk);
            waitCycles++;
            if (waitCycles > WaitLimit) failRun("timeout: done never pulsed");
        end
    endtask

    task automatic expectHit(input logic [31:0] addr, input logic exp);
        assert (lastHit === exp) else
            failRun($sformatf("CHECK FAILED hit at %h: got %h, expected %h", addr, lastHit, exp));
    endtask

    task automatic doStore(input logic [31:0] addr, input logic [31:0] data, input logic isByte);
        logic expHit;
        modelAccess(addr, 1'b0, expHit);
        if (isByte) begin
            refMem[addr[9:0]] = data[7:0];
        end else begin
            for (int i = 0; i < 4; i++) refMem[{addr[9:2], 2'(i)}] = data[8*i +: 8];
        end
        issue(addr, 1'b1, isByte, data);
        waitDone();
        assert (hit === expHit) else
            failRun($sformatf("CHECK FAILED hit on store %h: got %h, expected %h",
                addr, hit, expHit));
        @(negedge clk);
    endtask

    task automatic doLoad(input logic [31:0] addr, input logic isByte, input logic checkData);
        logic        expHit;
        logic [31:0] expData;
        modelAccess(addr, 1'b1, expHit);
        expData = isByte ? {24'b0, refMem[addr[9:0]]} : refWord(addr[9:0]);
        issue(addr, 1'b0, isByte, 32'h0);
        waitDone();
        lastHit = hit;
        assert (hit === expHit) else
            failRun($sformatf("CHECK FAILED hit at %h: got %h, expected %h", addr, hit, expHit));
        assert (!checkData || readData === expData) else
            failRun($sformatf("CHECK FAILED readData at %h: got %h, expected %h",
                addr, readData, expData));
        @(negedge clk);
    endtask

    task automatic checkBackPressure();
        logic        expHit;
        logic [31:0] expData;
        modelAccess(32'h2c0, 1'b1, expHit);
        expData = refWord(10'h2c0);
        issue(32'h2c0, 1'b0, 1'b0, 32'h0);
        @(negedge clk);
        assert (ready === 1'b0) else
            failRun($sformatf("CHECK FAILED ready during a load miss: got %h, expected 0",
                ready));
        address = 32'h2c4;   // store to the same line that must be dropped
        writeData = ~refWord(10'h2c4);
        memWrite = 1'b1;
        @(negedge clk);
        memWrite = 1'b0;
        waitDone();
        assert (hit === expHit) else
            failRun($sformatf("CHECK FAILED hit at 2c0: got %h, expected %h", hit, expHit));
        assert (readData === expData) else
            failRun($sformatf("CHECK FAILED readData at 2c0: got %h, expected %h",
                readData, expData));
        repeat (40) begin
            @(negedge clk);
            assert (done === 1'b0) else
                failRun($sformatf("CHECK FAILED done after an ignored strobe: got %h, expected 0",
                    done));
        end
        doLoad(32'h2c4, 1'b0, 1'b1);   // cached copy
        doLoad(32'h340, 1'b0, 1'b1);
        doLoad(32'h3c0, 1'b0, 1'b1);
        doLoad(32'h2c4, 1'b0, 1'b1);   // evicted so this one reads memory
        expectHit(32'h2c4, 1'b0);
    endtask

    initial begin
        logic [31:0] data;
        seed = 32'hbcc1;
        rst = 1'b1;
        memRead = 1'b0;
        memWrite = 1'b0;
        ldByte = 1'b0;
        stByte = 1'b0;
        address = 32'h0;
        writeData = 32'h0;
        lastHit = 1'b0;
        for (int s = 0; s < `DC_SETS; s++) begin
            modelValid[0][s] = 1'b0;
            modelValid[1][s] = 1'b0;
            modelLru[s] = 1'b0;
        end
        repeat (3) @(negedge clk);
        rst = 1'b0;

        // reset state while memory is still undefined
        assert (ready === 1'b1) else
            failRun($sformatf("CHECK FAILED ready after reset: got %h, expected 1", ready));
        assert (done === 1'b0) else
            failRun($sformatf("CHECK FAILED done after reset: got %h, expected 0", done));
        doLoad(32'h3f0, 1'b0, 1'b0);
        expectHit(32'h3f0, 1'b0);

        // word stores over all of memory and then LW per line
        for (int w = 0; w < `DC_MEM_WORDS; w++) begin
            data = $random(seed);
            doStore(32'(w * 4), data, 1'b0);
        end
        for (int ln = 0; ln < 8; ln++) begin
            for (int w = 0; w < 4; w++) begin
                doLoad(32'(ln * 16 + w * 4), 1'b0, 1'b1);
                expectHit(32'(ln * 16 + w * 4), w != 0);
            end
        end

        // LBU on a cached line and on a missing one
        for (int b = 0; b < 16; b++) doLoad(32'(b), 1'b1, 1'b1);
        for (int b = 0; b < 4; b++) doLoad(32'(32'h200 + b), 1'b1, 1'b1);

        // SW and SB hits before set 0 is evicted and reloaded
        data = $random(seed);
        doStore(32'h004, data, 1'b0);
        data = $random(seed);
        doStore(32'h009, data, 1'b1);
        data = $random(seed);
        doStore(32'h00e, data, 1'b1);
        doLoad(32'h004, 1'b0, 1'b1);
        doLoad(32'h008, 1'b0, 1'b1);
        doLoad(32'h00e, 1'b1, 1'b1);
        doLoad(32'h080, 1'b0, 1'b1);
        doLoad(32'h100, 1'b0, 1'b1);
        doLoad(32'h008, 1'b0, 1'b1);
        expectHit(32'h008, 1'b0);
        doLoad(32'h00c, 1'b0, 1'b1);

        // LRU in set 3 with A=030, B=0b0, C=130
        doLoad(32'h030, 1'b0, 1'b1);
        doLoad(32'h0b0, 1'b0, 1'b1);
        doLoad(32'h030, 1'b0, 1'b1);
        expectHit(32'h030, 1'b1);
        doLoad(32'h130, 1'b0, 1'b1);
        expectHit(32'h130, 1'b0);
        doLoad(32'h030, 1'b0, 1'b1);
        expectHit(32'h030, 1'b1);
        doLoad(32'h0b0, 1'b0, 1'b1);
        expectHit(32'h0b0, 1'b0);

        checkBackPressure();

        // every word through the cache against the reference
        for (int w = 0; w < `DC_MEM_WORDS; w++) doLoad(32'(w * 4), 1'b0, 1'b1);

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+rtl
rtl/dCachePkg.sv
rtl/accessDecode.sv
rtl/cacheWays.sv
rtl/cacheController.sv
rtl/loadFormatter.sv
rtl/backingMemory.sv
rtl/dataCacheTop.sv
tb/dataCacheTb.sv

//--- run.sh
#!/bin/sh
# build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module dataCacheTb -f sources.f -o dataCacheSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/dataCacheSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "Some tests failed" "$LOG"; then
    echo "simulation FAILED"
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "simulator exited with status $simStatus"
    exit 1
fi
if ! grep -q "All tests passed" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation PASSED"
exit 0
